/* files.f */
+incdir+logic
+incdir+test
logic/exu_pkg.sv
logic/gpr_file.sv
logic/exu_decode.sv
logic/exu_alu.sv
logic/lsu_lanes.sv
logic/next_pc.sv
logic/exu_top.sv
test/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - logic
    files:
      - logic/exu_pkg.sv
      - logic/gpr_file.sv
      - logic/exu_decode.sv
      - logic/exu_alu.sv
      - logic/lsu_lanes.sv
      - logic/next_pc.sv
      - logic/exu_top.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/exu_tb.sv

/* test/exu_ref_model.svh */
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// shadow register file, x0 kept at zero
word_t shadow_regs [`NUM_REGS];
// shadow memory, keyed by 8-byte word index
word_t shadow_mem [word_t];

// contents of a word never written, mixes every address bit
function automatic word_t mem_fill(word_t idx);
    return (idx * 64'h9e37_79b9_7f4a_7c15) ^ {idx[31:0], idx[63:32]};
endfunction

function automatic word_t read_shadow_mem(word_t addr);
    word_t idx;
    idx = addr / `BYTE_LANES;
    return shadow_mem.exists(idx) ? shadow_mem[idx] : mem_fill(idx);
endfunction

function automatic void apply_store(word_t addr, word_t data, lane_mask_t mask);
    word_t w;
    w = read_shadow_mem(addr);
    for (int i = 0; i < `BYTE_LANES; i++) begin
        if (mask[i]) begin
            w[i*8 +: 8] = data[i*8 +: 8];
        end
    end
    shadow_mem[addr / `BYTE_LANES] = w;
endfunction

function automatic void set_shadow_reg(reg_idx_t r, word_t v);
    if (r != 0) begin
        shadow_regs[r] = v;
    end
endfunction

// bytes moved by a load or store
function automatic int access_bytes(op_e o);
    case (o)
        OP_LB, OP_LBU, OP_SB: return 1;
        OP_LH, OP_LHU, OP_SH: return 2;
        OP_LW, OP_LWU, OP_SW: return 4;
        default:              return 8;
    endcase
endfunction

function automatic logic is_load(op_e o);
    return o inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD};
endfunction

function automatic logic is_store(op_e o);
    return o inside {OP_SB, OP_SH, OP_SW, OP_SD};
endfunction

function automatic logic writes_rd(op_e o);
    return !(is_store(o) || o == OP_NOP ||
             o inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU});
endfunction

// register and immediate forms share one table
function automatic word_t alu_expect(op_e o, word_t a, word_t b, word_t im, word_t p);
    word_t y;
    y = (o inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                   OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND}) ? b : im;
    case (o)
        OP_ADD, OP_ADDI:   return a + y;
        OP_SUB:            return a - y;
        OP_SLL, OP_SLLI:   return a << y[5:0];
        OP_SLT, OP_SLTI:   return word_t'($signed(a) < $signed(y));
        OP_SLTU, OP_SLTIU: return word_t'(a < y);
        OP_XOR, OP_XORI:   return a ^ y;
        OP_SRL, OP_SRLI:   return a >> y[5:0];
        OP_SRA, OP_SRAI:   return $signed(a) >>> y[5:0];
        OP_OR, OP_ORI:     return a | y;
        OP_AND, OP_ANDI:   return a & y;
        OP_LUI:            return im;
        OP_AUIPC:          return p + im;
        default:           return '0;
    endcase
endfunction

function automatic logic branch_taken(op_e o, word_t a, word_t b);
    case (o)
        OP_BEQ:  return a == b;
        OP_BNE:  return a != b;
        OP_BLT:  return $signed(a) < $signed(b);
        OP_BGE:  return $signed(a) >= $signed(b);
        OP_BLTU: return a < b;
        OP_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic word_t expect_npc(op_e o, word_t a, word_t b, word_t im, word_t p);
    case (o)
        OP_JAL:  return p + im;
        // jalr target drops bit 0
        OP_JALR: return (a + im) & ~word_t'(1);
        default: return branch_taken(o, a, b) ? p + im : p + `PC_STEP;
    endcase
endfunction

// gather the addressed bytes, then extend
function automatic word_t load_expect(op_e o, word_t addr);
    word_t w;
    word_t v;
    int n;
    n = access_bytes(o);
    w = read_shadow_mem(addr);
    v = '0;
    for (int i = 0; i < n; i++) begin
        v[i*8 +: 8] = w[(addr[2:0] + i)*8 +: 8];
    end
    if (o inside {OP_LB, OP_LH, OP_LW} && v[n*8-1]) begin
        v = v | ~((word_t'(1) << (n*8)) - 1);
    end
    return v;
endfunction

// low bytes of the source placed from the addressed lane upward
function automatic void store_lanes(input op_e o, input word_t addr, input word_t val,
                                    output word_t data, output lane_mask_t mask);
    int lane;
    lane = addr[2:0];
    data = '0;
    mask = '0;
    for (int i = 0; i < access_bytes(o); i++) begin
        data[(lane + i)*8 +: 8] = val[i*8 +: 8];
        mask[lane + i] = 1'b1;
    end
endfunction

function automatic word_t expect_wb(op_e o, word_t a, word_t b, word_t im, word_t p,
                                    word_t addr);
    if (o inside {OP_JAL, OP_JALR}) begin
        return p + `PC_STEP;
    end
    if (is_load(o)) begin
        return load_expect(o, addr);
    end
    return alu_expect(o, a, b, im, p);
endfunction

`endif

/* test/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_tb;

    import exu_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam int N_ALU = 200;
    localparam int N_MEM = 200;
    localparam int N_BR = 100;
    localparam int N_JMP = 50;
    // one cycle per op, loads, alu ops and jumps add a register dump
    localparam int TOTAL_OPS = RESET_CYCLES + 1 + 33 + 2*N_ALU + 2*N_MEM + N_BR + 2*N_JMP;
    // small load/store window so loads hit earlier stores
    localparam word_t WIN_BASE = 64'h100;
    localparam int WIN_BYTES = 128;

    logic       clk;
    logic       rst_n;
    op_e        op;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
    word_t      pc;
    word_t      mem_rdata;
    word_t      dnpc;
    word_t      mem_raddr;
    logic       mem_wen;
    word_t      mem_waddr;
    word_t      mem_wdata;
    lane_mask_t mem_wmask;

    // memory seen by the DUT, same fill as the shadow copy
    word_t tb_mem [word_t];
    int    mem_version;
    int    seed;

    `include "exu_ref_model.svh"

    exu_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .dnpc      (dnpc),
        .mem_raddr (mem_raddr),
        .mem_wen   (mem_wen),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic word_t tb_mem_word(word_t idx);
        return tb_mem.exists(idx) ? tb_mem[idx] : mem_fill(idx);
    endfunction

    // read answers in the same cycle
    always @(mem_raddr or mem_version) begin
        mem_rdata = tb_mem_word(mem_raddr / `BYTE_LANES);
    end

    // masked write on the rising edge
    always @(posedge clk) begin : mem_write
        word_t w;
        if (mem_wen) begin
            w = tb_mem_word(mem_waddr / `BYTE_LANES);
            for (int i = 0; i < `BYTE_LANES; i++) begin
                if (mem_wmask[i]) begin
                    w[i*8 +: 8] = mem_wdata[i*8 +: 8];
                end
            end
            tb_mem[mem_waddr / `BYTE_LANES] = w;
            mem_version++;
        end
    end

    task automatic stop_failed();
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            stop_failed();
        end
    endtask

    initial begin
        #(TOTAL_OPS * CLK_PERIOD * 2);
        $display("watchdog expired, the tests did not finish in time");
        stop_failed();
    end

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'(rand_below(`NUM_REGS));
    endfunction

    // uniform pick from a contiguous run of ops
    function automatic op_e pick_op(op_e first, op_e last);
        return op_e'(int'(first) + rand_below(int'(last) - int'(first) + 1));
    endfunction

    // size-aligned address inside the window
    function automatic word_t mem_target(int bytes);
        return WIN_BASE + word_t'(rand_below(WIN_BYTES / bytes) * bytes);
    endfunction

    // drive one op, check the same-cycle outputs, then update the shadow state
    task automatic run_op(input op_e o, input reg_idx_t d, input reg_idx_t s1,
                          input reg_idx_t s2, input word_t im, input word_t p,
                          input string name);
        word_t      a;
        word_t      b;
        word_t      addr;
        word_t      exp_data;
        lane_mask_t exp_mask;
        string      tag;
        @(posedge clk);
        op  <= o;
        rd  <= d;
        rs1 <= s1;
        rs2 <= s2;
        imm <= im;
        pc  <= p;
        // combinational outputs settled by the falling edge
        @(negedge clk);
        tag  = {name, " ", o.name()};
        a    = shadow_regs[s1];
        b    = shadow_regs[s2];
        addr = a + im;
        check({tag, " dnpc"}, expect_npc(o, a, b, im, p), dnpc);
        check({tag, " mem_raddr"}, is_load(o) ? addr : '0, mem_raddr);
        check({tag, " mem_wen"}, word_t'(is_store(o)), word_t'(mem_wen));
        if (is_store(o)) begin
            store_lanes(o, addr, b, exp_data, exp_mask);
            check({tag, " mem_waddr"}, addr, mem_waddr);
            check({tag, " mem_wdata"}, exp_data, mem_wdata);
            check({tag, " mem_wmask"}, word_t'(exp_mask), word_t'(mem_wmask));
            apply_store(addr, exp_data, exp_mask);
        end
        // DUT register write lands on the next rising edge
        if (writes_rd(o)) begin
            set_shadow_reg(d, expect_wb(o, a, b, im, p, addr));
        end
    endtask

    // sd of a register exposes its full value on mem_wdata
    task automatic show_reg(input reg_idx_t r);
        reg_idx_t base;
        base = rand_reg();
        run_op(OP_SD, '0, base, r, mem_target(8) - shadow_regs[base], rand_word(), "show_reg");
    endtask

    initial begin
        op_e      o;
        reg_idx_t d;
        reg_idx_t s1;
        reg_idx_t s2;
        reg_idx_t base;
        seed        = 17;
        mem_version = 0;
        rst_n       = 1'b0;
        op          = OP_NOP;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        imm         = '0;
        pc          = '0;
        mem_rdata   = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow_regs[i] = '0;
        end

        // a store held in reset must not reach memory
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            op  <= OP_SD;
            imm <= WIN_BASE;
            @(negedge clk);
            check("reset mem_wen", '0, word_t'(mem_wen));
        end
        @(posedge clk);
        rst_n <= 1'b1;
        op    <= OP_NOP;

        // registers all zero after reset
        show_reg('0);
        for (int r = 0; r < `NUM_REGS; r++) begin
            show_reg(reg_idx_t'(r));
        end

        // alu, lui, auipc
        repeat (N_ALU) begin
            o = pick_op(OP_ADD, OP_AUIPC);
            d = rand_reg();
            run_op(o, d, rand_reg(), rand_reg(), rand_word(), rand_word(), "alu");
            show_reg(d);
        end

        // loads and stores of every size
        repeat (N_MEM) begin
            o    = pick_op(OP_LB, OP_SD);
            d    = rand_reg();
            base = rand_reg();
            run_op(o, d, base, rand_reg(), mem_target(access_bytes(o)) - shadow_regs[base],
                   rand_word(), "mem");
            if (is_load(o)) begin
                show_reg(d);
            end
        end

        // equal operands now and then so beq/bge get taken
        repeat (N_BR) begin
            s1 = rand_reg();
            s2 = (rand_below(4) == 0) ? s1 : rand_reg();
            run_op(pick_op(OP_BEQ, OP_BGEU), rand_reg(), s1, s2, rand_word(), rand_word(),
                   "branch");
        end

        repeat (N_JMP) begin
            o = (rand_below(2) == 0) ? OP_JAL : OP_JALR;
            d = rand_reg();
            run_op(o, d, rand_reg(), rand_reg(), rand_word(), rand_word(), "jump");
            show_reg(d);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  exu_pkg::op_e        op,
    input  exu_pkg::reg_idx_t   rd,
    input  exu_pkg::reg_idx_t   rs1,
    input  exu_pkg::reg_idx_t   rs2,
    input  exu_pkg::word_t      imm,
    input  exu_pkg::word_t      pc,
    input  exu_pkg::word_t      mem_rdata,
    output exu_pkg::word_t      dnpc,
    output exu_pkg::word_t      mem_raddr,
    output logic                mem_wen,
    output exu_pkg::word_t      mem_waddr,
    output exu_pkg::word_t      mem_wdata,
    output exu_pkg::lane_mask_t mem_wmask
);

    import exu_pkg::*;

    word_t     src1;
    word_t     src2;
    word_t     operand_a;
    word_t     operand_b;
    word_t     alu_result;
    word_t     load_data;
    word_t     wb_data;
    word_t     link_pc;
    alu_mode_e alu_mode;
    wb_sel_e   wb_sel;
    mem_size_e mem_size;
    logic      gpr_wen;
    logic      mem_load;
    logic      mem_store;
    logic      mem_signed;
    logic      store_en;

    // no memory writes while reset is held
    assign store_en = mem_store & rst_n;

    gpr_file u_gpr (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (rd),
        .wen     (gpr_wen),
        .wdata   (wb_data),
        .rdata_a (src1),
        .rdata_b (src2)
    );

    exu_decode u_decode (
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .imm        (imm),
        .pc         (pc),
        .alu_mode   (alu_mode),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .wb_sel     (wb_sel),
        .gpr_wen    (gpr_wen),
        .mem_load   (mem_load),
        .mem_store  (mem_store),
        .mem_signed (mem_signed),
        .mem_size   (mem_size)
    );

    exu_alu u_alu (
        .mode   (alu_mode),
        .a      (operand_a),
        .b      (operand_b),
        .result (alu_result)
    );

    // alu sum is the effective address, rs2 the store data
    lsu_lanes u_lsu (
        .clk       (clk),
        .load      (mem_load),
        .store     (store_en),
        .is_signed (mem_signed),
        .size      (mem_size),
        .addr      (alu_result),
        .store_src (src2),
        .mem_rdata (mem_rdata),
        .mem_raddr (mem_raddr),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .load_data (load_data),
        .mem_wen   (mem_wen),
        .mem_wmask (mem_wmask)
    );

    next_pc u_npc (
        .op         (op),
        .pc         (pc),
        .imm        (imm),
        .alu_result (alu_result),
        .dnpc       (dnpc)
    );

    // return address for jal and jalr
    assign link_pc = pc + word_t'(`PC_STEP);

    // register writeback source
    always_comb begin
        case (wb_sel)
            WB_IMM:  wb_data = imm;
            WB_LINK: wb_data = link_pc;
            WB_LOAD: wb_data = load_data;
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* logic/next_pc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module next_pc (
    input  exu_pkg::op_e   op,
    input  exu_pkg::word_t pc,
    input  exu_pkg::word_t imm,
    input  exu_pkg::word_t alu_result,
    output exu_pkg::word_t dnpc
);

    import exu_pkg::*;

    word_t snpc;
    word_t branch_target;
    logic  taken;

    assign snpc          = pc + word_t'(`PC_STEP);
    assign branch_target = pc + imm;

    // branch decision from the alu compare
    always_comb begin
        case (op)
            // sub result, zero means equal
            OP_BEQ:          taken = (alu_result == '0);
            OP_BNE:          taken = (alu_result != '0);
            // slt and sltu give only 0 or 1
            OP_BLT, OP_BLTU: taken = alu_result[0];
            OP_BGE, OP_BGEU: taken = !alu_result[0];
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            // pc + imm from the alu
            OP_JAL:  dnpc = alu_result;
            // rs1 + imm with bit 0 dropped
            OP_JALR: dnpc = {alu_result[`XLEN-1:1], 1'b0};
            default: dnpc = taken ? branch_target : snpc;
        endcase
    end

endmodule

`default_nettype wire

/* logic/lsu_lanes.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module lsu_lanes (
    input  logic                clk,
    input  logic                load,
    input  logic                store,
    input  logic                is_signed,
    input  exu_pkg::mem_size_e  size,
    input  exu_pkg::word_t      addr,
    input  exu_pkg::word_t      store_src,
    input  exu_pkg::word_t      mem_rdata,
    output exu_pkg::word_t      mem_raddr,
    output exu_pkg::word_t      mem_waddr,
    output exu_pkg::word_t      mem_wdata,
    output exu_pkg::word_t      load_data,
    output logic                mem_wen,
    output exu_pkg::lane_mask_t mem_wmask
);

    import exu_pkg::*;

    localparam int LANE_W = $clog2(`BYTE_LANES);

    logic [LANE_W-1:0] lane;
    logic [LANE_W-1:0] align_bits;
    lane_mask_t        size_mask;
    word_t             size_bits;
    word_t             rdata_sh;

    // byte offset inside the memory word
    assign lane = addr[LANE_W-1:0];

    // bytes covered at lane 0, and low address bits that must be clear
    always_comb begin
        case (size)
            MEM_B: begin
                size_mask  = lane_mask_t'(8'h01);
                align_bits = LANE_W'(0);
            end
            MEM_H: begin
                size_mask  = lane_mask_t'(8'h03);
                align_bits = LANE_W'(1);
            end
            MEM_W: begin
                size_mask  = lane_mask_t'(8'h0f);
                align_bits = LANE_W'(3);
            end
            default: begin
                size_mask  = '1;
                align_bits = LANE_W'(7);
            end
        endcase
    end

    // byte mask widened to bits
    always_comb begin
        for (int i = 0; i < `BYTE_LANES; i++) begin
            size_bits[i*8 +: 8] = {8{size_mask[i]}};
        end
    end

    // store side, low bytes of the source moved up to the lane
    assign mem_wen   = store;
    assign mem_waddr = store ? addr : '0;
    assign mem_wdata = store ? ((store_src & size_bits) << {lane, 3'b000}) : '0;
    assign mem_wmask = store ? (size_mask << lane) : '0;

    // load side, addressed bytes moved down to lane 0
    assign mem_raddr = load ? addr : '0;
    assign rdata_sh  = mem_rdata >> {lane, 3'b000};

    always_comb begin
        case (size)
            MEM_B:
                load_data = {{(`XLEN-8){is_signed & rdata_sh[7]}}, rdata_sh[7:0]};
            MEM_H:
                load_data = {{(`XLEN-16){is_signed & rdata_sh[15]}}, rdata_sh[15:0]};
            MEM_W:
                load_data = {{(`XLEN-32){is_signed & rdata_sh[31]}}, rdata_sh[31:0]};
            default:
                load_data = rdata_sh;
        endcase
    end

    // lane crossing is not handled, every access must be naturally aligned
    a_aligned : assert property (@(posedge clk)
        (load || store) |-> ((lane & align_bits) == '0))
        else $error("lsu_lanes: misaligned access at %h", addr);

    // decode never asks for a load and a store together
    a_one_kind : assert property (@(posedge clk) !(load && store))
        else $error("lsu_lanes: load and store both active");

endmodule

`default_nettype wire

/* logic/exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_alu (
    input  exu_pkg::alu_mode_e mode,
    input  exu_pkg::word_t     a,
    input  exu_pkg::word_t     b,
    output exu_pkg::word_t     result
);

    import exu_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;

    // rv64 shifts use six bits of b
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (mode)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            // compares give 0 or 1
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/exu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_decode (
    input  exu_pkg::op_e       op,
    input  exu_pkg::word_t     src1,
    input  exu_pkg::word_t     src2,
    input  exu_pkg::word_t     imm,
    input  exu_pkg::word_t     pc,
    output exu_pkg::alu_mode_e alu_mode,
    output exu_pkg::word_t     operand_a,
    output exu_pkg::word_t     operand_b,
    output exu_pkg::wb_sel_e   wb_sel,
    output logic               gpr_wen,
    output logic               mem_load,
    output logic               mem_store,
    output logic               mem_signed,
    output exu_pkg::mem_size_e mem_size
);

    import exu_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic is_rr;
    logic is_reg_shift;
    logic is_branch;

    // ops that take rs2 as second operand
    assign is_rr = op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                              OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    assign is_reg_shift = op inside {OP_SLL, OP_SRL, OP_SRA};
    assign is_branch = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

    // pc-relative sums for auipc and jal
    assign operand_a = (op == OP_AUIPC || op == OP_JAL) ? pc : src1;

    // register shifts only see the low six bits of rs2
    assign operand_b = is_reg_shift ? word_t'(src2[SHAMT_W-1:0]) :
                       (is_rr || is_branch) ? src2 : imm;

    // alu function per op
    always_comb begin
        case (op)
            OP_SUB, OP_BEQ, OP_BNE:                alu_mode = ALU_SUB;
            OP_SLL, OP_SLLI:                       alu_mode = ALU_SLL;
            OP_SLT, OP_SLTI, OP_BLT, OP_BGE:       alu_mode = ALU_SLT;
            OP_SLTU, OP_SLTIU, OP_BLTU, OP_BGEU:   alu_mode = ALU_SLTU;
            OP_XOR, OP_XORI:                       alu_mode = ALU_XOR;
            OP_SRL, OP_SRLI:                       alu_mode = ALU_SRL;
            OP_SRA, OP_SRAI:                       alu_mode = ALU_SRA;
            OP_OR, OP_ORI:                         alu_mode = ALU_OR;
            OP_AND, OP_ANDI:                       alu_mode = ALU_AND;
            // add covers address and jump target sums too
            default:                               alu_mode = ALU_ADD;
        endcase
    end

    // writeback source
    always_comb begin
        case (op)
            OP_LUI:                                        wb_sel = WB_IMM;
            OP_JAL, OP_JALR:                               wb_sel = WB_LINK;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD: wb_sel = WB_LOAD;
            default:                                       wb_sel = WB_ALU;
        endcase
    end

    // access width, loads and stores share the encoding
    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_SB: mem_size = MEM_B;
            OP_LH, OP_LHU, OP_SH: mem_size = MEM_H;
            OP_LW, OP_LWU, OP_SW: mem_size = MEM_W;
            default:              mem_size = MEM_D;
        endcase
    end

    assign mem_load   = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD};
    assign mem_store  = op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    // ld counts as signed, no extension happens at full width
    assign mem_signed = op inside {OP_LB, OP_LH, OP_LW, OP_LD};

    // nothing to write for branches, stores and nop
    assign gpr_wen = !(is_branch || mem_store || op == OP_NOP);

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module gpr_file (
    input  logic              clk,
    input  logic              rst_n,
    input  exu_pkg::reg_idx_t raddr_a,
    input  exu_pkg::reg_idx_t raddr_b,
    input  exu_pkg::reg_idx_t waddr,
    input  logic              wen,
    input  exu_pkg::word_t    wdata,
    output exu_pkg::word_t    rdata_a,
    output exu_pkg::word_t    rdata_b
);

    import exu_pkg::*;

    word_t regs [`NUM_REGS];

    // single write port that skips x0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // two read ports without bypass of a same-cycle write
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // a write needs a known index and value
    a_wr_known : assert property (@(posedge clk) disable iff (!rst_n)
        wen |-> !$isunknown({waddr, wdata}))
        else $error("gpr_file: write with unknown index or data");

endmodule

`default_nettype wire

/* logic/exu_pkg.sv */
`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

    // one machine word, used for data, addresses and pc
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // one bit per byte lane of a memory word
    typedef logic [`BYTE_LANES-1:0] lane_mask_t;

    // decoded operation, already split out by the upstream decoder
    typedef enum logic [5:0] {
        // register/register
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // register/immediate
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        // upper immediates and jumps
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        // conditional branches
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // loads and stores
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD,
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_NOP
    } op_e;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_mode_e;

    // source of the register write value
    typedef enum logic [1:0] {
        WB_ALU, WB_IMM, WB_LINK, WB_LOAD
    } wb_sel_e;

    // access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        MEM_B, MEM_H, MEM_W, MEM_D
    } mem_size_e;

endpackage

`default_nettype wire

/* logic/exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data and address width
`define XLEN 64

// register index width
`define REG_ADDR_W 5

// architectural integer registers
`define NUM_REGS 32

// byte lanes per memory word, also the write mask width
`define BYTE_LANES 8

// sequential pc increment, one 32-bit instruction
`define PC_STEP 4

`endif
